/* rtl/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// address and data path widths
`define ADDR_WIDTH   32
`define WORD_WIDTH   64

// line holds four 64-bit words, 32 bytes
`define LINE_WORDS   4

// cache geometry
`define NUM_SETS     64
`define NUM_WAYS     2

// address split, tag + index + offset = ADDR_WIDTH
`define TAG_WIDTH    21
`define INDEX_WIDTH  6
`define OFFSET_WIDTH 5

`endif

/* rtl/dcachePkg.sv */
`default_nettype none

`include "dcache_defines.svh"

package dcachePkg;

  // byte address as seen by the cache
  typedef struct packed {
    logic [`TAG_WIDTH-1:0]    tag;
    logic [`INDEX_WIDTH-1:0]  index;
    logic [`OFFSET_WIDTH-1:0] offset;
  } cacheAddr_t;

  typedef enum logic {
    opLoad  = 1'b0,
    opStore = 1'b1
  } memOp_e;

  // one pipeline request, mask is one bit per byte of the word
  typedef struct packed {
    memOp_e                   op;
    cacheAddr_t               addr;
    logic [`WORD_WIDTH-1:0]   wrData;
    logic [`WORD_WIDTH/8-1:0] wrMask;
  } cacheReq_t;

  typedef enum logic [2:0] {
    stIdle,
    stCompare,
    stWriteBack,
    stMiss,
    stGetData,
    stReplace
  } cacheState_e;

  typedef logic [`LINE_WORDS*`WORD_WIDTH-1:0] lineData_t;

  // dirty line leaving the cache, addr is line aligned
  typedef struct packed {
    logic [`ADDR_WIDTH-1:0] addr;
    lineData_t              data;
  } wbReq_t;

endpackage

`default_nettype wire

/* rtl/dcacheCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheCtrl (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       reqValid_i,
  input  wire dcachePkg::cacheReq_t req_i,
  input  wire                       hit_i,
  input  wire                       victimDirty_i,
  input  wire [`TAG_WIDTH-1:0]      victimTag_i,
  input  wire                       wbReady_i,
  input  wire                       rdReady_i,
  input  wire                       rdLast_i,
  output logic                      reqReady_o,
  output logic                      dataOk_o,
  output dcachePkg::cacheReq_t      curReq_o,
  output logic                      storeWr_o,
  output logic                      refillWr_o,
  output logic                      wbValid_o,
  output logic [`ADDR_WIDTH-1:0]    wbAddr_o,
  output logic                      rdValid_o,
  output logic [`ADDR_WIDTH-1:0]    rdAddr_o,
  output logic                      refillEn_o
);
  import dcachePkg::*;

  cacheState_e curState;
  cacheState_e nextState;
  logic        reqAccept;

  assign reqReady_o = (curState == stIdle);
  assign reqAccept  = reqValid_i && reqReady_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= stIdle;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      stIdle: begin
        if (reqValid_i) begin
          nextState = stCompare;
        end
      end
      stCompare: begin
        // a dirty victim has to leave before the refill starts
        if (hit_i) begin
          nextState = stIdle;
        end else if (victimDirty_i) begin
          nextState = stWriteBack;
        end else begin
          nextState = stMiss;
        end
      end
      stWriteBack: begin
        if (wbReady_i) begin
          nextState = stMiss;
        end
      end
      stMiss: begin
        if (rdReady_i) begin
          nextState = stGetData;
        end
      end
      stGetData: begin
        if (rdLast_i) begin
          nextState = stReplace;
        end
      end
      stReplace: begin
        // retry, the line is now resident
        nextState = stCompare;
      end
      default: begin
        nextState = stIdle;
      end
    endcase
  end

  // request held for the whole miss sequence
  always_ff @(posedge clk) begin
    if (reqAccept) begin
      curReq_o <= req_i;
    end
  end

  assign dataOk_o   = (curState == stCompare) && hit_i;
  assign storeWr_o  = dataOk_o && (curReq_o.op == opStore);
  assign refillWr_o = (curState == stReplace);
  assign refillEn_o = (curState == stGetData);

  assign wbValid_o = (curState == stWriteBack);
  assign wbAddr_o  = {victimTag_i, curReq_o.addr.index, {`OFFSET_WIDTH{1'b0}}};

  // single read pulse, taken in the first cycle memory is ready
  assign rdValid_o = (curState == stMiss) && rdReady_i;
  assign rdAddr_o  = {curReq_o.addr.tag, curReq_o.addr.index, {`OFFSET_WIDTH{1'b0}}};

  // read request only for a line that is not resident
  assert property (@(posedge clk) disable iff (!rst_n)
    rdValid_o |-> !hit_i);

  // write-back request and its address hold until memory takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    wbValid_o && !wbReady_i |=> wbValid_o && $stable(wbAddr_o));

endmodule

`default_nettype wire

/* rtl/dcacheTagStore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheTagStore (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire dcachePkg::cacheReq_t curReq_i,
  input  wire                       storeWr_i,
  input  wire                       refillWr_i,
  output logic                      hit_o,
  output logic                      hitWay_o,
  output logic                      victimWay_o,
  output logic                      victimDirty_o,
  output logic [`TAG_WIDTH-1:0]     victimTag_o
);

  logic [`TAG_WIDTH-1:0]                 tagArr [`NUM_WAYS][`NUM_SETS];
  logic [`NUM_WAYS-1:0][`NUM_SETS-1:0]   validArr;
  logic [`NUM_WAYS-1:0][`NUM_SETS-1:0]   dirtyArr;
  logic [`NUM_WAYS-1:0]                  wayHit;
  logic [`INDEX_WIDTH-1:0]               idx;
  logic                                  victimSel;

  assign idx = curReq_i.addr.index;

  // tag compare against every way of the set
  always_comb begin
    for (int w = 0; w < `NUM_WAYS; w++) begin
      wayHit[w] = validArr[w][idx] && (tagArr[w][idx] == curReq_i.addr.tag);
    end
  end

  assign hit_o    = |wayHit;
  // two ways, so the way number is just the upper hit bit
  assign hitWay_o = wayHit[1];

  // toggle picks the way to replace, flips once per refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimSel <= 1'b0;
    end else if (refillWr_i) begin
      victimSel <= ~victimSel;
    end
  end

  assign victimWay_o   = victimSel;
  assign victimDirty_o = validArr[victimSel][idx] && dirtyArr[victimSel][idx];
  assign victimTag_o   = tagArr[victimSel][idx];

  always_ff @(posedge clk) begin
    if (refillWr_i) begin
      tagArr[victimSel][idx] <= curReq_i.addr.tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      dirtyArr <= '0;
    end else if (refillWr_i) begin
      // fresh line from memory is clean
      validArr[victimSel][idx] <= 1'b1;
      dirtyArr[victimSel][idx] <= 1'b0;
    end else if (storeWr_i) begin
      dirtyArr[hitWay_o][idx] <= 1'b1;
    end
  end

  // a line never lives in both ways of one set
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wayHit));

endmodule

`default_nettype wire

/* rtl/dcacheDataStore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheDataStore (
  input  wire                       clk,
  input  wire dcachePkg::cacheReq_t curReq_i,
  input  wire                       hitWay_i,
  input  wire                       victimWay_i,
  input  wire                       storeWr_i,
  input  wire                       refillWr_i,
  input  wire dcachePkg::lineData_t refillLine_i,
  output logic [`WORD_WIDTH-1:0]    rdData_o,
  output dcachePkg::lineData_t      victimLine_o
);
  import dcachePkg::*;

  localparam int MaskBits = `WORD_WIDTH / 8;
  localparam int ByteBits = $clog2(MaskBits);
  localparam int WordBits = $clog2(`LINE_WORDS);

  lineData_t               lineArr [`NUM_WAYS][`NUM_SETS];
  lineData_t               hitLine;
  logic [`INDEX_WIDTH-1:0] idx;
  logic [WordBits-1:0]     wordSel;
  logic [ByteBits-1:0]     byteOff;
  logic [`WORD_WIDTH-1:0]  oldWord;
  logic [`WORD_WIDTH-1:0]  shiftData;
  logic [MaskBits-1:0]     shiftMask;
  logic [`WORD_WIDTH-1:0]  bitMask;
  logic [`WORD_WIDTH-1:0]  mergedWord;

  assign idx     = curReq_i.addr.index;
  assign wordSel = curReq_i.addr.offset[ByteBits +: WordBits];
  assign byteOff = curReq_i.addr.offset[ByteBits-1:0];

  assign hitLine = lineArr[hitWay_i][idx];
  assign oldWord = hitLine[wordSel*`WORD_WIDTH +: `WORD_WIDTH];

  // move store data and mask to the addressed byte lane
  assign shiftData = curReq_i.wrData << {byteOff, 3'b000};
  assign shiftMask = curReq_i.wrMask << byteOff;

  always_comb begin
    for (int b = 0; b < MaskBits; b++) begin
      bitMask[b*8 +: 8] = {8{shiftMask[b]}};
    end
  end

  assign mergedWord = (oldWord & ~bitMask) | (shiftData & bitMask);

  always_ff @(posedge clk) begin
    if (refillWr_i) begin
      lineArr[victimWay_i][idx] <= refillLine_i;
    end else if (storeWr_i) begin
      lineArr[hitWay_i][idx][wordSel*`WORD_WIDTH +: `WORD_WIDTH] <= mergedWord;
    end
  end

  assign rdData_o     = oldWord;
  // line that goes out on a dirty eviction
  assign victimLine_o = lineArr[victimWay_i][idx];

endmodule

`default_nettype wire

/* rtl/dcacheRefill.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheRefill (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     refillEn_i,
  input  wire                     dataValid_i,
  input  wire                     rdLast_i,
  input  wire [`WORD_WIDTH-1:0]   rdData_i,
  output dcachePkg::lineData_t    refillLine_o
);
  import dcachePkg::*;

  localparam int BeatBits = $clog2(`LINE_WORDS);

  logic [BeatBits-1:0] beatCnt;
  logic                beatTake;
  lineData_t           lineBuf;

  assign beatTake = refillEn_i && dataValid_i;

  // wraps back to 0 after the fourth beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      beatCnt <= beatCnt + 1'b1;
    end else if (!refillEn_i) begin
      beatCnt <= '0;
    end
  end

  // beat k lands in word k
  always_ff @(posedge clk) begin
    if (beatTake) begin
      lineBuf[beatCnt*`WORD_WIDTH +: `WORD_WIDTH] <= rdData_i;
    end
  end

  assign refillLine_o = lineBuf;

  // memory marks only the last of the four beats
  assert property (@(posedge clk) disable iff (!rst_n)
    refillEn_i && rdLast_i |-> dataValid_i && (beatCnt == BeatBits'(`LINE_WORDS - 1)));

endmodule

`default_nettype wire

/* rtl/dcacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheTop (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       reqValid_i,
  input  wire dcachePkg::cacheReq_t req_i,
  input  wire                       wbReady_i,
  input  wire                       rdReady_i,
  input  wire                       dataValid_i,
  input  wire                       rdLast_i,
  input  wire [`WORD_WIDTH-1:0]     rdData_i,
  output logic                      reqReady_o,
  output logic                      dataOk_o,
  output logic [`WORD_WIDTH-1:0]    rdData_o,
  output logic                      wbValid_o,
  output dcachePkg::wbReq_t         wbReq_o,
  output logic                      rdValid_o,
  output logic [`ADDR_WIDTH-1:0]    rdAddr_o
);
  import dcachePkg::*;

  cacheReq_t              curReq;
  logic                   hit;
  logic                   hitWay;
  logic                   victimWay;
  logic                   victimDirty;
  logic [`TAG_WIDTH-1:0]  victimTag;
  logic                   storeWr;
  logic                   refillWr;
  logic                   refillEn;
  logic [`ADDR_WIDTH-1:0] wbAddr;
  lineData_t              victimLine;
  lineData_t              refillLine;

  dcacheCtrl i_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .req_i         (req_i),
    .hit_i         (hit),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .wbReady_i     (wbReady_i),
    .rdReady_i     (rdReady_i),
    .rdLast_i      (rdLast_i),
    .reqReady_o    (reqReady_o),
    .dataOk_o      (dataOk_o),
    .curReq_o      (curReq),
    .storeWr_o     (storeWr),
    .refillWr_o    (refillWr),
    .wbValid_o     (wbValid_o),
    .wbAddr_o      (wbAddr),
    .rdValid_o     (rdValid_o),
    .rdAddr_o      (rdAddr_o),
    .refillEn_o    (refillEn)
  );

  dcacheTagStore i_tagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .curReq_i      (curReq),
    .storeWr_i     (storeWr),
    .refillWr_i    (refillWr),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dcacheDataStore i_dataStore (
    .clk          (clk),
    .curReq_i     (curReq),
    .hitWay_i     (hitWay),
    .victimWay_i  (victimWay),
    .storeWr_i    (storeWr),
    .refillWr_i   (refillWr),
    .refillLine_i (refillLine),
    .rdData_o     (rdData_o),
    .victimLine_o (victimLine)
  );

  dcacheRefill i_refill (
    .clk          (clk),
    .rst_n        (rst_n),
    .refillEn_i   (refillEn),
    .dataValid_i  (dataValid_i),
    .rdLast_i     (rdLast_i),
    .rdData_i     (rdData_i),
    .refillLine_o (refillLine)
  );

  assign wbReq_o = '{addr: wbAddr, data: victimLine};

endmodule

`default_nettype wire

/* verification/dcacheMemModel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

// refill beats follow a fixed delay, write-back ready comes one cycle after valid
module dcacheMemModel (
  input  wire                     clk,
  input  wire                     rdValid_i,
  input  wire [`ADDR_WIDTH-1:0]   rdAddr_i,
  input  wire                     wbValid_i,
  input  wire dcachePkg::wbReq_t  wbReq_i,
  output logic                    rdReady_o,
  output logic                    dataValid_o,
  output logic                    rdLast_o,
  output logic [`WORD_WIDTH-1:0]  rdData_o,
  output logic                    wbReady_o,
  output int                      wbCount_o,
  output dcachePkg::wbReq_t       lastWb_o
);
  localparam int MemWords = 1024;
  localparam int Delay    = 3;

  logic [`WORD_WIDTH-1:0] mem [MemWords];
  logic [9:0]             rdWord;
  logic [31:0]            hi;
  logic [31:0]            lo;
  integer                 seed;
  int                     cnt;
  logic                   busy;

  initial begin
    seed = 90;
    for (int i = 0; i < MemWords; i++) begin
      hi = $random(seed);
      lo = $random(seed);
      mem[i] = {hi, lo};
    end
    rdReady_o   <= 1'b1;
    dataValid_o <= 1'b0;
    rdLast_o    <= 1'b0;
    rdData_o    <= '0;
    wbReady_o   <= 1'b0;
    wbCount_o   <= 0;
    lastWb_o    <= '0;
    busy = 1'b0;
    cnt = 0;
    rdWord = '0;
    forever begin
      @(posedge clk);
      dataValid_o <= 1'b0;
      rdLast_o    <= 1'b0;
      if (wbValid_i && wbReady_o) begin
        for (int k = 0; k < `LINE_WORDS; k++) begin
          mem[{wbReq_i.addr[12:5], k[1:0]}] = wbReq_i.data[k*`WORD_WIDTH +: `WORD_WIDTH];
        end
        wbCount_o <= wbCount_o + 1;
        lastWb_o  <= wbReq_i;
      end
      wbReady_o <= wbValid_i && !wbReady_o;
      if (busy) begin
        cnt = cnt + 1;
        // one beat per cycle once the delay is over
        if (cnt > Delay) begin
          dataValid_o <= 1'b1;
          rdLast_o    <= (cnt == Delay + `LINE_WORDS);
          rdData_o    <= mem[rdWord];
          rdWord = rdWord + 10'd1;
          busy = (cnt < Delay + `LINE_WORDS);
        end
      end else if (rdValid_i) begin
        busy = 1'b1;
        cnt = 0;
        rdWord = rdAddr_i[12:3];
      end
      rdReady_o <= !busy;
    end
  end

endmodule

`default_nettype wire

/* verification/dcacheTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheTb;
  import dcachePkg::*;

  // name is eight characters
  typedef struct packed {
    logic [63:0]              name;
    memOp_e                   op;
    logic [`ADDR_WIDTH-1:0]   addr;
    logic [`WORD_WIDTH-1:0]   data;
    logic [`WORD_WIDTH/8-1:0] mask;
  } tblEntry_t;

  localparam int NumTests      = 10;
  localparam int TimeoutCycles = NumTests * 40 + 20;

  logic                   clk;
  logic                   rst_n;
  logic                   reqValid;
  cacheReq_t              req;
  logic                   reqReady;
  logic                   dataOk;
  logic [`WORD_WIDTH-1:0] rdData;
  logic                   wbValid;
  wbReq_t                 wbReq;
  logic                   wbReady;
  logic                   rdValid;
  logic [`ADDR_WIDTH-1:0] rdAddr;
  logic                   rdReady;
  logic                   dataValid;
  logic                   rdLast;
  logic [`WORD_WIDTH-1:0] memData;
  int                     wbCount;
  wbReq_t                 lastWb;
  tblEntry_t              tbl [NumTests];
  int                     cycleCnt = 0;

  // reference image of memory and of both ways of every set
  logic [`WORD_WIDTH-1:0] refMem [1024];
  logic [`TAG_WIDTH-1:0]  refTag [`NUM_SETS][`NUM_WAYS];
  logic                   refValid [`NUM_SETS][`NUM_WAYS];
  logic                   refDirty [`NUM_SETS][`NUM_WAYS];
  lineData_t              refLine [`NUM_SETS][`NUM_WAYS];
  logic                   refToggle;
  logic                   expMiss;
  logic                   expWb;
  logic [`ADDR_WIDTH-1:0] expWbAddr;
  lineData_t              expWbLine;
  logic [`WORD_WIDTH-1:0] expData;

  dcacheTop i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqValid_i  (reqValid),
    .req_i       (req),
    .wbReady_i   (wbReady),
    .rdReady_i   (rdReady),
    .dataValid_i (dataValid),
    .rdLast_i    (rdLast),
    .rdData_i    (memData),
    .reqReady_o  (reqReady),
    .dataOk_o    (dataOk),
    .rdData_o    (rdData),
    .wbValid_o   (wbValid),
    .wbReq_o     (wbReq),
    .rdValid_o   (rdValid),
    .rdAddr_o    (rdAddr)
  );

  dcacheMemModel i_mem (
    .clk         (clk),
    .rdValid_i   (rdValid),
    .rdAddr_i    (rdAddr),
    .wbValid_i   (wbValid),
    .wbReq_i     (wbReq),
    .rdReady_o   (rdReady),
    .dataValid_o (dataValid),
    .rdLast_o    (rdLast),
    .rdData_o    (memData),
    .wbReady_o   (wbReady),
    .wbCount_o   (wbCount),
    .lastWb_o    (lastWb)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkEq(input string testName, input string what,
                         input logic [255:0] expected, input logic [255:0] actual);
    if (expected !== actual) begin
      abortRun($sformatf("Error: %s %s expected %0h actual %0h",
                         testName, what, expected, actual));
    end
  endtask

  // walks the reference image through one request
  task automatic predict(input tblEntry_t e);
    logic [`INDEX_WIDTH-1:0] idx;
    logic [`TAG_WIDTH-1:0]   tag;
    logic [1:0]              wordSel;
    logic [2:0]              off;
    logic [`WORD_WIDTH-1:0]  w;
    logic                    way;
    logic                    found;
    idx = e.addr[10:5];
    tag = e.addr[31:11];
    wordSel = e.addr[4:3];
    off = e.addr[2:0];
    found = 1'b0;
    way = 1'b0;
    for (int v = 0; v < `NUM_WAYS; v++) begin
      if (refValid[idx][v] && refTag[idx][v] == tag) begin
        found = 1'b1;
        way = v[0];
      end
    end
    expMiss = !found;
    expWb = 1'b0;
    if (expMiss) begin
      way = refToggle;
      expWb = refValid[idx][way] && refDirty[idx][way];
      if (expWb) begin
        expWbAddr = {refTag[idx][way], idx, 5'b0};
        expWbLine = refLine[idx][way];
        for (int k = 0; k < `LINE_WORDS; k++) begin
          refMem[{refTag[idx][way][1:0], idx, k[1:0]}] = expWbLine[k*64 +: 64];
        end
      end
      for (int k = 0; k < `LINE_WORDS; k++) begin
        refLine[idx][way][k*64 +: 64] = refMem[{tag[1:0], idx, k[1:0]}];
      end
      refTag[idx][way] = tag;
      refValid[idx][way] = 1'b1;
      refDirty[idx][way] = 1'b0;
      refToggle = ~refToggle;
    end
    w = refLine[idx][way][wordSel*64 +: 64];
    if (e.op == opStore) begin
      // byte b of the store lands in byte b + offset, bytes past the word drop out
      for (int b = 0; b < 8; b++) begin
        if (e.mask[b] && (b + off < 8)) begin
          w[(b + off)*8 +: 8] = e.data[b*8 +: 8];
        end
      end
      refLine[idx][way][wordSel*64 +: 64] = w;
      refDirty[idx][way] = 1'b1;
    end
    expData = w;
  endtask

  always @(posedge clk) begin
    cycleCnt = cycleCnt + 1;
    if (cycleCnt >= TimeoutCycles) begin
      abortRun($sformatf("timeout: the cache did not finish within %0d cycles", cycleCnt));
    end
  end

  initial begin
    integer                 seed;
    logic [31:0]            hi;
    logic [31:0]            lo;
    string                  tn;
    int                     cycles;
    int                     rdPulses;
    int                     wbBefore;
    logic [`ADDR_WIDTH-1:0] rdAddrSeen;
    rst_n = 1'b0;
    reqValid = 1'b0;
    req = '0;
    rdAddrSeen = '0;
    // same fill sequence as the memory model
    seed = 90;
    for (int i = 0; i < 1024; i++) begin
      hi = $random(seed);
      lo = $random(seed);
      refMem[i] = {hi, lo};
    end
    for (int s = 0; s < `NUM_SETS; s++) begin
      for (int v = 0; v < `NUM_WAYS; v++) begin
        refValid[s][v] = 1'b0;
        refDirty[s][v] = 1'b0;
        refTag[s][v] = '0;
        refLine[s][v] = '0;
      end
    end
    refToggle = 1'b0;
    // tags 0..2 share index 5, entry 5 evicts the dirty line of entry 2
    tbl[0] = {"ldMissA ", opLoad,  32'h0000_00A8, 64'h0, 8'h00};
    tbl[1] = {"ldHitA  ", opLoad,  32'h0000_00B8, 64'h0, 8'h00};
    tbl[2] = {"stPartA ", opStore, 32'h0000_00B3, 64'h1122_3344_5566_7788, 8'h86};
    tbl[3] = {"ldBackA ", opLoad,  32'h0000_00B0, 64'h0, 8'h00};
    tbl[4] = {"ldMissB ", opLoad,  32'h0000_08A0, 64'h0, 8'h00};
    tbl[5] = {"ldMissC ", opLoad,  32'h0000_10A8, 64'h0, 8'h00};
    tbl[6] = {"ldEvictA", opLoad,  32'h0000_00B0, 64'h0, 8'h00};
    tbl[7] = {"stFullD ", opStore, 32'h0000_1928, 64'h0123_4567_89AB_CDEF, 8'hFF};
    tbl[8] = {"ldFullD ", opLoad,  32'h0000_1928, 64'h0, 8'h00};
    tbl[9] = {"ldMissE ", opLoad,  32'h0000_07E8, 64'h0, 8'h00};
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    checkEq("reset", "reqReady", 256'(1), 256'(reqReady));
    checkEq("reset", "dataOk", 256'(0), 256'(dataOk));
    checkEq("reset", "wbValid", 256'(0), 256'(wbValid));
    checkEq("reset", "rdValid", 256'(0), 256'(rdValid));
    for (int i = 0; i < NumTests; i++) begin
      tn = $sformatf("%s", tbl[i].name);
      predict(tbl[i]);
      while (!reqReady) @(posedge clk);
      wbBefore = wbCount;
      reqValid <= 1'b1;
      req <= {tbl[i].op, tbl[i].addr, tbl[i].data, tbl[i].mask};
      @(posedge clk);
      reqValid <= 1'b0;
      cycles = 0;
      rdPulses = 0;
      do begin
        @(posedge clk);
        cycles++;
        if (rdValid) begin
          rdPulses++;
          rdAddrSeen = rdAddr;
        end
      end while (!dataOk);
      checkEq(tn, "rdValid pulses", 256'(expMiss), 256'(rdPulses));
      if (expMiss) begin
        checkEq(tn, "rdAddr", 256'({tbl[i].addr[31:5], 5'b0}), 256'(rdAddrSeen));
      end else begin
        checkEq(tn, "hit latency", 256'(1), 256'(cycles));
      end
      checkEq(tn, "write-backs", 256'(wbBefore + int'(expWb)), 256'(wbCount));
      if (expWb) begin
        checkEq(tn, "wbAddr", 256'(expWbAddr), 256'(lastWb.addr));
        checkEq(tn, "wbLine", expWbLine, lastWb.data);
      end
      if (tbl[i].op == opLoad) begin
        checkEq(tn, "rdData", 256'(expData), 256'(rdData));
      end
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* dcacheTop.f */
+incdir+rtl
rtl/dcachePkg.sv
rtl/dcacheCtrl.sv
rtl/dcacheTagStore.sv
rtl/dcacheDataStore.sv
rtl/dcacheRefill.sv
rtl/dcacheTop.sv
verification/dcacheMemModel.sv
verification/dcacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module dcacheTb -f dcacheTop.f -o dcacheSim &&
./obj_dir/dcacheSim ||
{ echo "simulation failed"; exit 1; }
